/* verilog/obj_pkg.sv */
// --------------------------------------
// Shared widths, sprite records and FSM
// states for the sprite unit
// --------------------------------------

package obj_pkg;

    localparam int NUM_SPRITES = 128;

    typedef logic [7:0]  coord_t;
    typedef logic [8:0]  oam_addr_t;
    typedef logic [7:0]  oam_byte_t;
    typedef logic [14:0] vram_addr_t;
    typedef logic [15:0] vram_word_t;
    typedef logic [3:0]  color_t;
    typedef logic [2:0]  palette_t;
    typedef logic [1:0]  prior_t;
    typedef logic [7:0]  tile_t;
    typedef logic [2:0]  fine_t;

    // One sprite found on the line with its fine row already y-flipped
    typedef struct packed {
        coord_t   x;
        tile_t    tile;
        palette_t palette;
        prior_t   prior;
        logic     x_flip;
        fine_t    fine_row;
    } list_entry_t;

    // One fetched sprite with planes in screen order
    typedef struct packed {
        coord_t     x;
        logic [7:0] plane0;
        logic [7:0] plane1;
        logic [7:0] plane2;
        logic [7:0] plane3;
        palette_t   palette;
        prior_t     prior;
        logic       valid;
    } slot_t;

    typedef enum logic [2:0] {
        EVAL_IDLE,
        EVAL_Y,
        EVAL_TILE,
        EVAL_ATTR,
        EVAL_X
    } eval_state_t;

    function automatic int idx_width(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    function automatic int cnt_width(input int n);
        return $clog2(n + 1);
    endfunction

endpackage

/* verilog/sprite_list_if.sv */
// --------------------------------------
// Per-line sprite list from evaluation
// to tile fetch
// --------------------------------------

`timescale 1ns/1ps

interface sprite_list_if #(
    parameter int MAX_PER_LINE = 32
);

    localparam int IDX_W = obj_pkg::idx_width(MAX_PER_LINE);
    localparam int CNT_W = obj_pkg::cnt_width(MAX_PER_LINE);

    logic [CNT_W-1:0]     count;
    logic [IDX_W-1:0]     rd_index;
    obj_pkg::list_entry_t entry;

    // Entry follows rd_index in the same cycle
    modport producer (
        output count,
        output entry,
        input  rd_index
    );

    modport consumer (
        input  count,
        input  entry,
        output rd_index
    );

endinterface

/* verilog/slot_write_if.sv */
// --------------------------------------
// Slot writes from tile fetch into the
// next-line buffer
// --------------------------------------

`timescale 1ns/1ps

interface slot_write_if #(
    parameter int MAX_PER_LINE = 32
);

    localparam int IDX_W = obj_pkg::idx_width(MAX_PER_LINE);

    logic             we;
    logic [IDX_W-1:0] index;
    obj_pkg::slot_t   slot;
    logic             clear;

    modport writer (output we, output index, output slot, output clear);
    modport buffer (input we, input index, input slot, input clear);

endinterface

/* verilog/sprite_eval.sv */
// --------------------------------------
// Sprite evaluation with OAM scan, Y range
// test, list storage and range overflow
// --------------------------------------

`timescale 1ns/1ps

module sprite_eval #(
    parameter int MAX_PER_LINE = 32
) (
    input  logic               clk,
    input  logic               reset,
    input  obj_pkg::coord_t    y,
    input  logic               start,
    input  logic               newline,
    input  logic               ovf_clear,
    input  obj_pkg::oam_byte_t oam_rdata,
    output obj_pkg::oam_addr_t oam_addr,
    output logic               oam_read,
    output logic               busy,
    output logic               range_ovf_flg,
    sprite_list_if.producer    list
);

    localparam int IDX_W = obj_pkg::idx_width(MAX_PER_LINE);
    localparam int CNT_W = obj_pkg::cnt_width(MAX_PER_LINE);
    localparam int SPR_W = $clog2(obj_pkg::NUM_SPRITES);

    obj_pkg::eval_state_t state;
    logic [SPR_W-1:0]     sprite_ctr;
    logic [CNT_W-1:0]     count;
    obj_pkg::fine_t       fine_reg;
    obj_pkg::list_entry_t entries [MAX_PER_LINE];

    logic [8:0]       y_diff;
    logic             y_hit;
    logic             list_full;
    logic             last_sprite;
    logic [1:0]       byte_sel;
    logic [IDX_W-1:0] wr_idx;

    // Line must sit 0..7 rows below the sprite top without wrap
    assign y_diff      = {1'b0, y} - {1'b0, oam_rdata};
    assign y_hit       = ~y_diff[8] & (y_diff[7:3] == 5'd0);
    assign list_full   = (count == CNT_W'(MAX_PER_LINE));
    assign last_sprite = (sprite_ctr == SPR_W'(obj_pkg::NUM_SPRITES - 1));
    assign wr_idx      = count[IDX_W-1:0];

    always_comb begin
        case (state)
            obj_pkg::EVAL_TILE: byte_sel = 2'd2;
            obj_pkg::EVAL_ATTR: byte_sel = 2'd3;
            obj_pkg::EVAL_X:    byte_sel = 2'd0;
            default:            byte_sel = 2'd1;
        endcase
    end

    assign oam_addr = {sprite_ctr, byte_sel};
    assign oam_read = (state != obj_pkg::EVAL_IDLE);
    assign busy     = (state != obj_pkg::EVAL_IDLE);

    assign list.count = count;
    assign list.entry = entries[list.rd_index];

    // --------------------------------------
    // Scan FSM
    // --------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= obj_pkg::EVAL_IDLE;
            sprite_ctr <= '0;
        end else begin
            case (state)
                obj_pkg::EVAL_IDLE: begin
                    if (start) begin
                        state      <= obj_pkg::EVAL_Y;
                        sprite_ctr <= '0;
                    end
                end
                obj_pkg::EVAL_Y: begin
                    if (y_hit & list_full) begin
                        state <= obj_pkg::EVAL_IDLE;
                    end else if (y_hit) begin
                        state <= obj_pkg::EVAL_TILE;
                    end else if (last_sprite) begin
                        state <= obj_pkg::EVAL_IDLE;
                    end else begin
                        sprite_ctr <= sprite_ctr + 1'b1;
                    end
                end
                obj_pkg::EVAL_TILE: state <= obj_pkg::EVAL_ATTR;
                obj_pkg::EVAL_ATTR: state <= obj_pkg::EVAL_X;
                obj_pkg::EVAL_X: begin
                    if (last_sprite) begin
                        state <= obj_pkg::EVAL_IDLE;
                    end else begin
                        state      <= obj_pkg::EVAL_Y;
                        sprite_ctr <= sprite_ctr + 1'b1;
                    end
                end
                default: state <= obj_pkg::EVAL_IDLE;
            endcase
        end
    end

    // Entry is committed once its X byte is read
    always_ff @(posedge clk) begin
        if (reset | newline) begin
            count <= '0;
        end else if (state == obj_pkg::EVAL_X) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == obj_pkg::EVAL_Y) begin
            fine_reg <= y_diff[2:0];
        end
    end

    // --------------------------------------
    // List storage
    // --------------------------------------

    always_ff @(posedge clk) begin
        case (state)
            obj_pkg::EVAL_TILE: entries[wr_idx].tile <= oam_rdata;
            obj_pkg::EVAL_ATTR: begin
                entries[wr_idx].palette  <= oam_rdata[3:1];
                entries[wr_idx].prior    <= oam_rdata[5:4];
                entries[wr_idx].x_flip   <= oam_rdata[6];
                entries[wr_idx].fine_row <= fine_reg ^ {3{oam_rdata[7]}};
            end
            obj_pkg::EVAL_X: entries[wr_idx].x <= oam_rdata;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset | ovf_clear) begin
            range_ovf_flg <= 1'b0;
        end else if ((state == obj_pkg::EVAL_Y) & y_hit & list_full) begin
            range_ovf_flg <= 1'b1;
        end
    end

endmodule

/* verilog/tile_fetch.sv */
// --------------------------------------
// VRAM addressing and plane capture for
// each listed sprite
// --------------------------------------

`timescale 1ns/1ps

module tile_fetch #(
    parameter int MAX_PER_LINE = 32
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic [2:0]          name_base,
    input  obj_pkg::vram_word_t vram_rdata,
    output obj_pkg::vram_addr_t vram_addr,
    output logic                vram_read,
    output logic                busy,
    sprite_list_if.consumer     list,
    slot_write_if.writer        wr
);

    localparam int IDX_W = obj_pkg::idx_width(MAX_PER_LINE);
    localparam int CNT_W = obj_pkg::cnt_width(MAX_PER_LINE);

    logic             active;
    logic             word_sel;
    logic [IDX_W-1:0] idx;
    logic [7:0]       plane0;
    logic [7:0]       plane1;

    obj_pkg::list_entry_t cur;
    logic [7:0]           lo_byte;
    logic [7:0]           hi_byte;
    logic                 last_entry;

    function automatic logic [7:0] reverse8(input logic [7:0] b);
        logic [7:0] r;
        for (int i = 0; i < 8; i++) begin
            r[i] = b[7-i];
        end
        return r;
    endfunction

    assign list.rd_index = idx;
    assign cur           = list.entry;
    assign last_entry    = (CNT_W'(idx) + CNT_W'(1) == list.count);

    assign busy      = active;
    assign vram_read = active;
    assign vram_addr = obj_pkg::vram_addr_t'({name_base, 13'h0}
                     + {4'h0, cur.tile, word_sel, cur.fine_row});

    assign lo_byte = cur.x_flip ? reverse8(vram_rdata[7:0]) : vram_rdata[7:0];
    assign hi_byte = cur.x_flip ? reverse8(vram_rdata[15:8]) : vram_rdata[15:8];

    // Two words per entry with planes 0/1 then planes 2/3
    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= 1'b0;
            word_sel <= 1'b0;
            idx      <= '0;
        end else if (start) begin
            active   <= (list.count != '0);
            word_sel <= 1'b0;
            idx      <= '0;
        end else if (active) begin
            word_sel <= ~word_sel;
            if (word_sel) begin
                if (last_entry) begin
                    active <= 1'b0;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (active & ~word_sel) begin
            plane0 <= lo_byte;
            plane1 <= hi_byte;
        end
    end

    always_comb begin
        wr.we            = active & word_sel;
        wr.index         = idx;
        wr.clear         = start;
        wr.slot.x        = cur.x;
        wr.slot.plane0   = plane0;
        wr.slot.plane1   = plane1;
        wr.slot.plane2   = lo_byte;
        wr.slot.plane3   = hi_byte;
        wr.slot.palette  = cur.palette;
        wr.slot.prior    = cur.prior;
        wr.slot.valid    = 1'b1;
    end

endmodule

/* verilog/line_render.sv */
// --------------------------------------
// Line buffers and per-pixel sprite
// selection
// --------------------------------------

`timescale 1ns/1ps

module line_render #(
    parameter int MAX_PER_LINE = 32
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              newline,
    input  obj_pkg::coord_t   x,
    output obj_pkg::color_t   pixel_color,
    output obj_pkg::palette_t pixel_palette,
    output obj_pkg::prior_t   pixel_prior,
    slot_write_if.buffer      wr
);

    obj_pkg::slot_t next_slots [MAX_PER_LINE];
    obj_pkg::slot_t cur_slots  [MAX_PER_LINE];

    // Next-line buffer
    always_ff @(posedge clk) begin
        if (reset | newline | wr.clear) begin
            for (int i = 0; i < MAX_PER_LINE; i++) begin
                next_slots[i].valid <= 1'b0;
            end
        end else if (wr.we) begin
            next_slots[wr.index] <= wr.slot;
        end
    end

    // Current-line buffer swapped in on newline
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MAX_PER_LINE; i++) begin
                cur_slots[i].valid <= 1'b0;
            end
        end else if (newline) begin
            cur_slots <= next_slots;
        end
    end

    // First opaque slot in list order wins
    always_comb begin
        logic           found;
        logic [8:0]     diff;
        obj_pkg::fine_t bit_idx;
        obj_pkg::color_t color;

        found         = 1'b0;
        pixel_color   = '0;
        pixel_palette = '0;
        pixel_prior   = '0;
        for (int i = 0; i < MAX_PER_LINE; i++) begin
            diff    = {1'b0, x} - {1'b0, cur_slots[i].x};
            // bit 7 is the leftmost column
            bit_idx = ~diff[2:0];
            color   = {cur_slots[i].plane3[bit_idx], cur_slots[i].plane2[bit_idx],
                       cur_slots[i].plane1[bit_idx], cur_slots[i].plane0[bit_idx]};
            if (~found & cur_slots[i].valid & ~diff[8] & (diff[7:3] == 5'd0)
                    & (color != '0)) begin
                found         = 1'b1;
                pixel_color   = color;
                pixel_palette = cur_slots[i].palette;
                pixel_prior   = cur_slots[i].prior;
            end
        end
    end

endmodule

/* verilog/obj_unit.sv */
// --------------------------------------
// Sprite unit top level with evaluation,
// fetch, rendering and busy gating
// --------------------------------------

`timescale 1ns/1ps

module obj_unit #(
    parameter int MAX_PER_LINE = 32
) (
    input  logic                clk,
    input  logic                reset,
    input  obj_pkg::coord_t     y,
    input  obj_pkg::coord_t     x,
    input  logic [2:0]          name_base,
    input  logic                newline,
    input  logic                start_eval,
    input  logic                start_fetch,
    input  logic                ovf_clear,
    input  obj_pkg::oam_byte_t  oam_rdata,
    input  obj_pkg::vram_word_t vram_rdata,
    output obj_pkg::oam_addr_t  oam_addr,
    output logic                oam_read,
    output obj_pkg::vram_addr_t vram_addr,
    output logic                vram_read,
    output logic                busy,
    output logic                range_ovf_flg,
    output obj_pkg::color_t     pixel_color,
    output obj_pkg::palette_t   pixel_palette,
    output obj_pkg::prior_t     pixel_prior
);

    logic eval_busy;
    logic fetch_busy;
    logic idle;

    sprite_list_if #(.MAX_PER_LINE(MAX_PER_LINE)) list_bus ();
    slot_write_if  #(.MAX_PER_LINE(MAX_PER_LINE)) slot_bus ();

    assign busy = eval_busy | fetch_busy;
    assign idle = ~busy;

    // Control pulses are only taken between phases
    sprite_eval #(.MAX_PER_LINE(MAX_PER_LINE)) u_eval (
        .clk           (clk),
        .reset         (reset),
        .y             (y),
        .start         (start_eval & idle),
        .newline       (newline & idle),
        .ovf_clear     (ovf_clear & idle),
        .oam_rdata     (oam_rdata),
        .oam_addr      (oam_addr),
        .oam_read      (oam_read),
        .busy          (eval_busy),
        .range_ovf_flg (range_ovf_flg),
        .list          (list_bus)
    );

    tile_fetch #(.MAX_PER_LINE(MAX_PER_LINE)) u_fetch (
        .clk        (clk),
        .reset      (reset),
        .start      (start_fetch & idle),
        .name_base  (name_base),
        .vram_rdata (vram_rdata),
        .vram_addr  (vram_addr),
        .vram_read  (vram_read),
        .busy       (fetch_busy),
        .list       (list_bus),
        .wr         (slot_bus)
    );

    line_render #(.MAX_PER_LINE(MAX_PER_LINE)) u_render (
        .clk           (clk),
        .reset         (reset),
        .newline       (newline & idle),
        .x             (x),
        .pixel_color   (pixel_color),
        .pixel_palette (pixel_palette),
        .pixel_prior   (pixel_prior),
        .wr            (slot_bus)
    );

endmodule

/* tests/obj_unit_props.sv */
// ----------------------------------------
// Port-level properties of the sprite unit
// ----------------------------------------

`timescale 1ns/1ps

module obj_unit_props (
    input logic clk,
    input logic reset,
    input logic start_fetch,
    input logic busy,
    input logic oam_read,
    input logic vram_read,
    input logic range_ovf_flg
);

    // Idle outputs right after reset
    reset_idle: assert property (@(posedge clk)
        reset |=> (!busy && !oam_read && !vram_read && !range_ovf_flg))
        else $error("outputs not idle in the cycle after reset");

    one_memory: assert property (@(posedge clk) disable iff (reset)
        !(oam_read && vram_read))
        else $error("OAM and VRAM read in the same cycle");

    // A fetch only begins after start_fetch is taken while idle
    fetch_busy: assert property (@(posedge clk) disable iff (reset)
        $rose(vram_read) |-> busy && $past(start_fetch && !busy))
        else $error("VRAM reads began without an accepted start_fetch");

endmodule

/* tests/obj_unit_tb.sv */
// ----------------------------------------
// Sprite unit testbench with clock, reset,
// OAM and VRAM models and data-driven tests
// ----------------------------------------

`timescale 1ns/1ps

module obj_unit_tb;

    localparam int TD_DEPTH        = 256;
    localparam int CYCLES_PER_TEST = 600;

    logic                clk;
    logic                reset;
    obj_pkg::coord_t     y;
    obj_pkg::coord_t     x;
    logic [2:0]          name_base;
    logic                newline;
    logic                start_eval;
    logic                start_fetch;
    logic                ovf_clear;
    obj_pkg::oam_byte_t  oam_rdata;
    obj_pkg::vram_word_t vram_rdata;
    obj_pkg::oam_addr_t  oam_addr;
    logic                oam_read;
    obj_pkg::vram_addr_t vram_addr;
    logic                vram_read;
    logic                busy;
    logic                range_ovf_flg;
    obj_pkg::color_t     pixel_color;
    obj_pkg::palette_t   pixel_palette;
    obj_pkg::prior_t     pixel_prior;

    obj_pkg::oam_byte_t  oam_mem  [512];
    obj_pkg::vram_word_t vram_mem [32768];
    logic [39:0]         td       [TD_DEPTH];
    logic [8:0]          exp_line [256];

    string test_name;
    int    num_tests;
    int    rd_ptr;
    int    cycle_limit;
    int    cycles;

    // Both memories answer in the same cycle
    assign oam_rdata  = oam_mem[oam_addr];
    assign vram_rdata = vram_mem[vram_addr];

    obj_unit #(.MAX_PER_LINE(32)) DUT (
        .clk           (clk),
        .reset         (reset),
        .y             (y),
        .x             (x),
        .name_base     (name_base),
        .newline       (newline),
        .start_eval    (start_eval),
        .start_fetch   (start_fetch),
        .ovf_clear     (ovf_clear),
        .oam_rdata     (oam_rdata),
        .vram_rdata    (vram_rdata),
        .oam_addr      (oam_addr),
        .oam_read      (oam_read),
        .vram_addr     (vram_addr),
        .vram_read     (vram_read),
        .busy          (busy),
        .range_ovf_flg (range_ovf_flg),
        .pixel_color   (pixel_color),
        .pixel_palette (pixel_palette),
        .pixel_prior   (pixel_prior)
    );

    bind obj_unit obj_unit_props props (
        .clk           (clk),
        .reset         (reset),
        .start_fetch   (start_fetch),
        .busy          (busy),
        .oam_read      (oam_read),
        .vram_read     (vram_read),
        .range_ovf_flg (range_ovf_flg)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if ((cycle_limit > 0) && (cycles >= cycle_limit)) begin
            $display("Timeout: the run went past %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic fail_run();
        $display("TEST FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic expect_equal(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("CHECK FAILED %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            fail_run();
        end
    endtask

    task automatic line_break();
        newline = 1'b1;
        tick();
        newline = 1'b0;
    endtask

    task automatic count_tests();
        int          p;
        logic [39:0] hdr;
        p         = 0;
        num_tests = 0;
        while ((p + 1 < TD_DEPTH) && (td[p] != '0)) begin
            hdr = td[p + 1];
            p   = p + 2 + int'(hdr[15:12]) + int'(hdr[11:8]) + int'(hdr[7:0]);
            num_tests++;
        end
    endtask

    task automatic fill_memories();
        logic [8:0]  oa;
        logic [14:0] va;
        for (int i = 0; i < 512; i++) begin
            oa = 9'(i);
            // Y byte parks unused sprites at line 128 or below
            if (oa[1:0] == 2'd1) begin
                oam_mem[i] = {1'b1, oa[8:2]};
            end else begin
                oam_mem[i] = oa[8:1] ^ oa[7:0];
            end
        end
        for (int i = 0; i < 32768; i++) begin
            va          = 15'(i);
            vram_mem[i] = {va[7:0], va[14:7]} ^ 16'h5a5a;
        end
    endtask

    // ----------------------------------------
    // One test loads, evaluates, fetches, sweeps
    // ----------------------------------------

    task automatic run_test();
        logic [39:0] hdr;
        logic [39:0] rec;
        int          sprite;
        int          busy_cycles;

        test_name = $sformatf("%s", td[rd_ptr]);
        hdr       = td[rd_ptr + 1];
        rd_ptr    = rd_ptr + 2;
        fill_memories();
        sprite = 0;
        for (int g = 0; g < int'(hdr[15:12]); g++) begin
            rec = td[rd_ptr];
            rd_ptr++;
            for (int r = 0; r < int'(rec[39:32]); r++) begin
                oam_mem[4 * sprite]     = rec[31:24];
                oam_mem[4 * sprite + 1] = rec[23:16];
                oam_mem[4 * sprite + 2] = rec[15:8];
                oam_mem[4 * sprite + 3] = rec[7:0];
                sprite++;
            end
        end
        for (int v = 0; v < int'(hdr[11:8]); v++) begin
            rec = td[rd_ptr];
            rd_ptr++;
            vram_mem[rec[30:16]] = rec[15:0];
        end
        for (int i = 0; i < 256; i++) begin
            exp_line[i] = '0;
        end
        for (int k = 0; k < int'(hdr[7:0]); k++) begin
            rec = td[rd_ptr];
            rd_ptr++;
            exp_line[rec[19:12]] = {rec[11:8], rec[6:4], rec[1:0]};
        end

        line_break();
        y          = hdr[39:32];
        name_base  = hdr[30:28];
        start_eval = 1'b1;
        tick();
        start_eval = 1'b0;
        assert (busy) else begin
            $display("Evaluation did not start in test %s", test_name);
            fail_run();
        end
        while (busy) begin
            tick();
        end
        expect_equal("range overflow flag", int'(hdr[27:24]), int'(range_ovf_flg));

        start_fetch = 1'b1;
        tick();
        start_fetch = 1'b0;
        busy_cycles = 0;
        while (busy) begin
            busy_cycles++;
            tick();
        end
        expect_equal("fetch busy cycles", int'(hdr[23:16]), busy_cycles);

        line_break();
        // Outputs are combinational in x and sampled mid-cycle
        for (int i = 0; i < 256; i++) begin
            x = 8'(i);
            @(negedge clk);
            expect_equal($sformatf("pixel {color,palette,prior} at x=%0d", i),
                         int'(exp_line[i]),
                         int'({pixel_color, pixel_palette, pixel_prior}));
            tick();
        end

        ovf_clear = 1'b1;
        tick();
        ovf_clear = 1'b0;
        expect_equal("flag after ovf_clear", 0, int'(range_ovf_flg));
    endtask

    initial begin
        reset       = 1'b1;
        y           = '0;
        x           = '0;
        name_base   = '0;
        newline     = 1'b0;
        start_eval  = 1'b0;
        start_fetch = 1'b0;
        ovf_clear   = 1'b0;
        cycles      = 0;
        cycle_limit = 0;
        rd_ptr      = 0;
        for (int i = 0; i < TD_DEPTH; i++) begin
            td[i] = '0;
        end
        $readmemh("tests/obj_testdata.txt", td);
        count_tests();
        assert (num_tests > 0) else begin
            $display("No tests were found in the data file");
            fail_run();
        end
        cycle_limit = CYCLES_PER_TEST * num_tests;
        fill_memories();

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        tick();

        for (int t = 0; t < num_tests; t++) begin
            run_test();
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

/* tests/obj_testdata.txt */
// Per test: name (ASCII), header y_base_flag_fetch_nspr_nvram_npix, sprite groups
// rep_X_Y_tile_attr, VRAM words addr_data, expected pixels x_color_palette_prior
53494E474C 20_1_0_02_1_2_08 01_40_1D_05_26
2053_CCF0 205B_01AA
40_7_3_2 41_3_3_2 42_5_3_2 43_1_3_2 44_6_3_2 45_2_3_2 46_4_3_2 47_8_3_2
4F564C4150 30_0_0_04_2_4_0C 01_50_30_10_02 01_54_2E_11_3A
0100_00FC 0108_FC00 0112_FF00 011A_0000
50_9_1_0 51_9_1_0 52_9_1_0 53_9_1_0 54_9_1_0 55_9_1_0
56_2_5_3 57_2_5_3 58_2_5_3 59_2_5_3 5A_2_5_3 5B_2_5_3
464C495053 40_2_0_06_3_4_0A 01_10_3E_22_04 01_20_3E_22_C4 01_30_3E_22_44
4222_10E0 422A_0000 4225_0000 422D_0103
10_1_2_0 11_1_2_0 12_1_2_0 13_2_2_0 20_C_2_0 21_4_2_0 34_2_2_0 35_1_2_0 36_1_2_0
37_1_2_0
4F56464C57 60_3_1_40_2_2_01 20_08_60_33_1C 01_90_60_33_1C
6330_0080 6338_0000
08_1_6_1
4645544348 70_1_0_04_5_4_0C
01_40_10_44_3E 01_F8_6A_44_3E 01_60_78_44_3E 01_00_69_44_3E 01_80_68_44_3E
2446_FF00 244E_0000 2447_000F 244F_0000
F8_2_7_3 F9_2_7_3 FA_2_7_3 FB_2_7_3 FC_2_7_3 FD_2_7_3 FE_2_7_3 FF_2_7_3
04_1_7_3 05_1_7_3 06_1_7_3 07_1_7_3
0000000000

/* sim.f */
verilog/obj_pkg.sv
verilog/sprite_list_if.sv
verilog/slot_write_if.sv
verilog/sprite_eval.sv
verilog/tile_fetch.sv
verilog/line_render.sv
verilog/obj_unit.sv
tests/obj_unit_props.sv
tests/obj_unit_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = obj_unit_tb
FILELIST  = sim.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
